//--- build.f
ex_pkg.sv
ex_intf.sv
ex_alu.sv
ex_mult.sv
ex_stage.sv
tb_ex_stage_sva.sv
tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  # Design
  - ex_pkg.sv
  - ex_intf.sv
  - ex_alu.sv
  - ex_mult.sv
  - ex_stage.sv
  # Testbench
  - target: test
    files:
      - tb_ex_stage_sva.sv
      - tb_ex_stage.sv

//--- tb_ex_stage.sv
// Testbench for the execute stage
// Random ALU ops, multiplies, back-pressure, EX/WB register and reset checks
`timescale 1ns/1ps

module tb_ex_stage;

  logic                          clk;
  logic                          rst_n;
  ex_pkg::alu_op_e               alu_operator;
  logic [ex_pkg::DATA_W-1:0]     alu_a;
  logic [ex_pkg::DATA_W-1:0]     alu_b;
  logic [ex_pkg::DATA_W-1:0]     alu_c;
  logic                          mult_en;
  ex_pkg::mult_op_e              mult_operator;
  logic [ex_pkg::DATA_W-1:0]     mult_a;
  logic [ex_pkg::DATA_W-1:0]     mult_b;
  logic [ex_pkg::DATA_W-1:0]     mult_c;
  logic                          branch_in_ex;
  logic [ex_pkg::REG_ADDR_W-1:0] alu_waddr;
  logic                          alu_we;
  logic                          we;
  logic [ex_pkg::REG_ADDR_W-1:0] waddr;
  logic                          csr_access;
  logic [ex_pkg::DATA_W-1:0]     csr_rdata;
  logic                          lsu_ready;
  logic                          wb_ready;
  // DUT outputs
  logic                          multicycle;
  logic [ex_pkg::REG_ADDR_W-1:0] waddr_wb;
  logic                          we_wb;
  logic [ex_pkg::REG_ADDR_W-1:0] alu_waddr_fw;
  logic                          alu_we_fw;
  logic [ex_pkg::DATA_W-1:0]     wdata_fw;
  logic [ex_pkg::DATA_W-1:0]     jump_target;
  logic                          branch_decision;
  logic                          ex_ready;
  logic                          ex_valid;
  // Bookkeeping
  integer                        seed;
  logic [31:0]                   rnd;
  int                            errors;
  int                            checks;
  int                            test_base;
  int                            cycles;
  logic [ex_pkg::REG_ADDR_W-1:0] addr_exp;

  ex_stage u_dut (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_operator_i         (alu_operator),
    .alu_operand_a_i        (alu_a),
    .alu_operand_b_i        (alu_b),
    .alu_operand_c_i        (alu_c),
    .mult_en_i              (mult_en),
    .mult_operator_i        (mult_operator),
    .mult_operand_a_i       (mult_a),
    .mult_operand_b_i       (mult_b),
    .mult_operand_c_i       (mult_c),
    .mult_multicycle_o      (multicycle),
    .branch_in_ex_i         (branch_in_ex),
    .regfile_alu_waddr_i    (alu_waddr),
    .regfile_alu_we_i       (alu_we),
    .regfile_we_i           (we),
    .regfile_waddr_i        (waddr),
    .csr_access_i           (csr_access),
    .csr_rdata_i            (csr_rdata),
    .regfile_waddr_wb_o     (waddr_wb),
    .regfile_we_wb_o        (we_wb),
    .regfile_alu_waddr_fw_o (alu_waddr_fw),
    .regfile_alu_we_fw_o    (alu_we_fw),
    .regfile_alu_wdata_fw_o (wdata_fw),
    .jump_target_o          (jump_target),
    .branch_decision_o      (branch_decision),
    .lsu_ready_ex_i         (lsu_ready),
    .wb_ready_i             (wb_ready),
    .ex_ready_o             (ex_ready),
    .ex_valid_o             (ex_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Expected forwarding data and branch decision
  function automatic void ref_result(
    input  ex_pkg::alu_op_e           aop,
    input  logic [ex_pkg::DATA_W-1:0] a,
    input  logic [ex_pkg::DATA_W-1:0] b,
    input  ex_pkg::mult_op_e          mop,
    input  logic [ex_pkg::DATA_W-1:0] ma,
    input  logic [ex_pkg::DATA_W-1:0] mb,
    input  logic [ex_pkg::DATA_W-1:0] mc,
    input  logic                      men,
    input  logic                      csr,
    input  logic [ex_pkg::DATA_W-1:0] csr_data,
    output logic [ex_pkg::DATA_W-1:0] data,
    output logic                      br
  );
    logic [2*ex_pkg::DATA_W-1:0] ea;
    logic [2*ex_pkg::DATA_W-1:0] eb;
    logic [2*ex_pkg::DATA_W-1:0] prod;
    logic [ex_pkg::DATA_W-1:0]   alu;
    case (aop)
      ex_pkg::ALU_NE:  br = (a != b);
      ex_pkg::ALU_LT:  br = ($signed(a) < $signed(b));
      ex_pkg::ALU_GE:  br = ($signed(a) >= $signed(b));
      ex_pkg::ALU_LTU: br = (a < b);
      ex_pkg::ALU_GEU: br = (a >= b);
      // EQ and every non-branch operator
      default:         br = (a == b);
    endcase
    case (aop)
      ex_pkg::ALU_ADD:  alu = a + b;
      ex_pkg::ALU_SUB:  alu = a - b;
      ex_pkg::ALU_AND:  alu = a & b;
      ex_pkg::ALU_OR:   alu = a | b;
      ex_pkg::ALU_XOR:  alu = a ^ b;
      ex_pkg::ALU_SLL:  alu = a << b[4:0];
      ex_pkg::ALU_SRL:  alu = a >> b[4:0];
      ex_pkg::ALU_SRA:  alu = $signed(a) >>> b[4:0];
      ex_pkg::ALU_SLT:  alu = ($signed(a) < $signed(b)) ? 1 : 0;
      ex_pkg::ALU_SLTU: alu = (a < b) ? 1 : 0;
      default:          alu = {{(ex_pkg::DATA_W-1){1'b0}}, br};
    endcase
    // Sign extension only for the signed high product
    ea = (mop == ex_pkg::MUL_HSS) ? {{ex_pkg::DATA_W{ma[ex_pkg::DATA_W-1]}}, ma}
                                  : {{ex_pkg::DATA_W{1'b0}}, ma};
    eb = (mop == ex_pkg::MUL_HSS) ? {{ex_pkg::DATA_W{mb[ex_pkg::DATA_W-1]}}, mb}
                                  : {{ex_pkg::DATA_W{1'b0}}, mb};
    prod = ea * eb;
    if (mop == ex_pkg::MUL_MAC)
      prod = prod + {{ex_pkg::DATA_W{1'b0}}, mc};
    if (men)
      data = (mop == ex_pkg::MUL_HSS || mop == ex_pkg::MUL_HUU)
           ? prod[2*ex_pkg::DATA_W-1:ex_pkg::DATA_W] : prod[ex_pkg::DATA_W-1:0];
    else if (csr)
      data = csr_data;
    else
      data = alu;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_data(input string name, input logic [ex_pkg::DATA_W-1:0] exp_v,
                            input logic [ex_pkg::DATA_W-1:0] act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      errors++;
      $display("Fail %s: expected %b, actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_addr(input string name, input logic [ex_pkg::REG_ADDR_W-1:0] exp_v,
                            input logic [ex_pkg::REG_ADDR_W-1:0] act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  // Forwarding data and branch decision against the model
  task automatic verify_outputs(input string name);
    logic [ex_pkg::DATA_W-1:0] exp_data;
    logic                      exp_br;
    ref_result(alu_operator, alu_a, alu_b, mult_operator, mult_a, mult_b, mult_c,
               mult_en, csr_access, csr_rdata, exp_data, exp_br);
    check_data({name, " data"}, exp_data, wdata_fw);
    check_bit({name, " branch"}, exp_br, branch_decision);
  endtask

  task automatic report_test(input string name);
    $display("Test %s finished, %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////

  task automatic set_defaults();
    alu_operator  = ex_pkg::ALU_ADD;
    alu_a         = '0;
    alu_b         = '0;
    alu_c         = '0;
    mult_en       = 1'b0;
    mult_operator = ex_pkg::MUL_LO;
    mult_a        = '0;
    mult_b        = '0;
    mult_c        = '0;
    branch_in_ex  = 1'b0;
    alu_waddr     = '0;
    alu_we        = 1'b0;
    we            = 1'b0;
    waddr         = '0;
    csr_access    = 1'b0;
    csr_rdata     = '0;
    lsu_ready     = 1'b1;
    wb_ready      = 1'b1;
  endtask

  // Sampled 1 ns after each falling edge
  task automatic wait_valid(input string name, input logic busy_check, output int n);
    n = 0;
    while (!ex_valid && n < 50)
    begin
      if (busy_check)
        check_bit({name, " multicycle"}, 1'b1, multicycle);
      @(negedge clk);
      #1;
      n++;
    end
    if (!ex_valid)
    begin
      errors++;
      $display("Timeout in %s: ex_valid_o did not rise within 50 cycles", name);
    end
  endtask

  task automatic wait_mult_done(input string name);
    int n;
    n = 0;
    while (multicycle && n < 50)
    begin
      @(negedge clk);
      #1;
      n++;
    end
    if (multicycle)
    begin
      errors++;
      $display("Timeout in %s: multiplier still busy after 50 cycles", name);
    end
  endtask

  task automatic run_mult(input ex_pkg::mult_op_e op, input logic [ex_pkg::DATA_W-1:0] a,
                          input logic [ex_pkg::DATA_W-1:0] b,
                          input logic [ex_pkg::DATA_W-1:0] c);
    string name;
    int    n;
    name = $sformatf("mult %s", op.name());
    @(negedge clk);
    mult_en       = 1'b1;
    mult_operator = op;
    mult_a        = a;
    mult_b        = b;
    mult_c        = c;
    #1;
    wait_valid(name, 1'b1, n);
    check_data({name, " latency"}, ex_pkg::MULT_CYCLES + 1, n);
    verify_outputs(name);
    // Drop the request once the stage has taken it
    @(negedge clk);
    mult_en = 1'b0;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial
  begin
    seed      = 32'h93fe0598;
    errors    = 0;
    checks    = 0;
    test_base = 0;
    rst_n     = 1'b0;
    set_defaults();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;

    check_bit("reset we_wb", 1'b0, we_wb);
    check_addr("reset waddr_wb", '0, waddr_wb);
    check_bit("reset multicycle", 1'b0, multicycle);
    report_test("reset_values");

    // Random ALU operators, operands equal now and then
    for (int i = 0; i < 200; i++)
    begin
      @(negedge clk);
      rnd          = $random(seed);
      alu_operator = ex_pkg::alu_op_e'(rnd[3:0]);
      alu_a        = $random(seed);
      alu_b        = (rnd[5:4] == 2'b00) ? alu_a : $random(seed);
      alu_waddr    = rnd[12:8];
      alu_we       = rnd[16];
      #1;
      verify_outputs($sformatf("alu %s", alu_operator.name()));
      check_addr("alu waddr_fw", alu_waddr, alu_waddr_fw);
      check_bit("alu we_fw", alu_we, alu_we_fw);
    end
    report_test("alu_ops");

    @(negedge clk);
    alu_we     = 1'b0;
    alu_c      = $random(seed);
    csr_access = 1'b1;
    csr_rdata  = $random(seed);
    #1;
    check_data("jump target", alu_c, jump_target);
    verify_outputs("csr read");
    @(negedge clk);
    csr_access   = 1'b0;
    branch_in_ex = 1'b1;
    wb_ready     = 1'b0;
    #1;
    check_bit("branch ex_ready", 1'b1, ex_ready);
    check_bit("branch ex_valid", 1'b0, ex_valid);
    @(negedge clk);
    branch_in_ex = 1'b0;
    wb_ready     = 1'b1;
    report_test("branch_csr");

    for (int k = 0; k < 4; k++)
    begin
      repeat (4) run_mult(ex_pkg::mult_op_e'(k), $random(seed), $random(seed), $random(seed));
      // Most negative times minus one, then all ones
      run_mult(ex_pkg::mult_op_e'(k), 32'h8000_0000, 32'hffff_ffff, $random(seed));
      run_mult(ex_pkg::mult_op_e'(k), 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
    end
    report_test("multiplier");

    // Writeback stalled across the whole multiply
    @(negedge clk);
    wb_ready      = 1'b0;
    mult_en       = 1'b1;
    mult_operator = ex_pkg::MUL_HSS;
    mult_a        = $random(seed);
    mult_b        = $random(seed);
    #1;
    wait_mult_done("backpressure");
    repeat (3)
    begin
      @(negedge clk);
      #1;
      check_bit("backpressure ex_valid", 1'b0, ex_valid);
      verify_outputs("backpressure held");
    end
    @(negedge clk);
    wb_ready = 1'b1;
    #1;
    wait_valid("backpressure release", 1'b0, cycles);
    // Result already waiting, valid follows wb_ready at once
    check_data("backpressure release latency", 32'd0, cycles);
    verify_outputs("backpressure released");
    @(negedge clk);
    mult_en = 1'b0;
    report_test("backpressure");

    we       = 1'b1;
    rnd      = $random(seed);
    waddr    = rnd[4:0];
    addr_exp = rnd[4:0];
    @(negedge clk);
    check_bit("exwb we", 1'b1, we_wb);
    check_addr("exwb waddr", addr_exp, waddr_wb);
    we    = 1'b0;
    waddr = ~addr_exp;
    @(negedge clk);
    check_bit("exwb we cleared", 1'b0, we_wb);
    check_addr("exwb waddr held", addr_exp, waddr_wb);
    we = 1'b1;
    @(negedge clk);
    check_bit("exwb we again", 1'b1, we_wb);
    // No valid while writeback is ready gives a bubble
    lsu_ready = 1'b0;
    @(negedge clk);
    check_bit("exwb bubble", 1'b0, we_wb);
    lsu_ready = 1'b1;
    @(negedge clk);
    alu_we = 1'b1;
    #1;
    check_bit("conflict ex_ready", 1'b0, ex_ready);
    @(negedge clk);
    branch_in_ex = 1'b1;
    #1;
    check_bit("conflict branch ex_ready", 1'b1, ex_ready);
    @(negedge clk);
    set_defaults();
    report_test("exwb_register");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- tb_ex_stage_sva.sv
// Execute stage assertions
// Handshake levels and EX/WB register reset and hold behavior
`timescale 1ns/1ps

module ex_stage_sva (
  input logic clk,
  input logic rst_n,
  input logic wb_ready_i,
  input logic lsu_ready_ex_i,
  input logic ex_valid_o,
  input logic mult_multicycle_o,
  input logic regfile_we_wb_o
);

  // Valid only with both consumers ready
  valid_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |-> (wb_ready_i && lsu_ready_ex_i))
    else $error("ex_valid_o high without wb_ready_i and lsu_ready_ex_i");

  // Busy multiplier blocks valid
  busy_blocks_valid: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_o |-> !ex_valid_o)
    else $error("ex_valid_o high while the multiplier is busy");

  we_low_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !regfile_we_wb_o)
    else $error("regfile_we_wb_o set in the first cycle after reset");

  // Stalled writeback freezes the EX/WB enable
  we_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(regfile_we_wb_o))
    else $error("regfile_we_wb_o changed while wb_ready_i was low");

endmodule

bind ex_stage ex_stage_sva u_sva (
  .clk               (clk),
  .rst_n             (rst_n),
  .wb_ready_i        (wb_ready_i),
  .lsu_ready_ex_i    (lsu_ready_ex_i),
  .ex_valid_o        (ex_valid_o),
  .mult_multicycle_o (mult_multicycle_o),
  .regfile_we_wb_o   (regfile_we_wb_o)
);

//--- ex_stage.sv
// Execute stage top level
// ALU, multiplier, result mux, EX/WB register and stall control
`timescale 1ns/1ps

module ex_stage (
  input  logic                          clk,
  input  logic                          rst_n,

  // ALU operands from decode
  input  ex_pkg::alu_op_e               alu_operator_i,
  input  logic [ex_pkg::DATA_W-1:0]     alu_operand_a_i,
  input  logic [ex_pkg::DATA_W-1:0]     alu_operand_b_i,
  input  logic [ex_pkg::DATA_W-1:0]     alu_operand_c_i,

  // Multiplier request
  input  logic                          mult_en_i,
  input  ex_pkg::mult_op_e              mult_operator_i,
  input  logic [ex_pkg::DATA_W-1:0]     mult_operand_a_i,
  input  logic [ex_pkg::DATA_W-1:0]     mult_operand_b_i,
  input  logic [ex_pkg::DATA_W-1:0]     mult_operand_c_i,
  output logic                          mult_multicycle_o,

  input  logic                          branch_in_ex_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                          regfile_alu_we_i,

  // Passed on to writeback
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,

  input  logic                          csr_access_i,
  input  logic [ex_pkg::DATA_W-1:0]     csr_rdata_i,

  // EX/WB register
  output logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic                          regfile_we_wb_o,

  // Forwarding to decode and register file
  output logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic                          regfile_alu_we_fw_o,
  output logic [ex_pkg::DATA_W-1:0]     regfile_alu_wdata_fw_o,

  // Branch resolution to fetch
  output logic [ex_pkg::DATA_W-1:0]     jump_target_o,
  output logic                          branch_decision_o,

  // Stall control
  input  logic                          lsu_ready_ex_i,
  input  logic                          wb_ready_i,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);

  ex_alu_if  alu_if ();
  ex_mult_if mult_if ();

  logic [ex_pkg::DATA_W-1:0] alu_csr_result;
  logic                      we_conflict;

  ////////////////////
  // ALU
  ////////////////////

  assign alu_if.operator  = alu_operator_i;
  assign alu_if.operand_a = alu_operand_a_i;
  assign alu_if.operand_b = alu_operand_b_i;

  ex_alu u_alu (
    .alu (alu_if.alu)
  );

  ////////////////////
  // Multiplier
  ////////////////////

  assign mult_if.en       = mult_en_i;
  assign mult_if.operator = mult_operator_i;
  assign mult_if.op_a     = mult_operand_a_i;
  assign mult_if.op_b     = mult_operand_b_i;
  assign mult_if.op_c     = mult_operand_c_i;
  assign mult_if.ex_ready = ex_ready_o;

  ex_mult u_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .mul   (mult_if.mult)
  );

  assign mult_multicycle_o = mult_if.multicycle;

  ////////////////////
  // Result mux
  ////////////////////

  // Multiplier over CSR over ALU
  assign alu_csr_result         = csr_access_i ? csr_rdata_i : alu_if.result;
  assign regfile_alu_wdata_fw_o = mult_en_i ? mult_if.result : alu_csr_result;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;

  // Target computed in decode
  assign jump_target_o     = alu_operand_c_i;
  assign branch_decision_o = alu_if.cmp_result;

  ////////////////////
  // Stall control
  ////////////////////

  // Single write port, WB and ALU write cannot share a cycle
  assign we_conflict = regfile_we_wb_o & regfile_alu_we_i;

  assign ex_valid_o = mult_if.ready & lsu_ready_ex_i & wb_ready_i;
  // Branches finish here without a writeback slot
  assign ex_ready_o = (ex_valid_o & ~we_conflict) | branch_in_ex_i;

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end
    else if (ex_valid_o)
    begin
      regfile_we_wb_o <= regfile_we_i;
      // Address only moves with a real write
      if (regfile_we_i)
        regfile_waddr_wb_o <= regfile_waddr_i;
    end
    else if (wb_ready_i)
    begin
      // Bubble into writeback
      regfile_we_wb_o <= 1'b0;
    end
  end

endmodule

//--- ex_mult.sv
// Iterative multiplier, one byte of op_b per cycle
// Low product, signed/unsigned high products and multiply-accumulate
`timescale 1ns/1ps

module ex_mult (
  input  logic     clk,
  input  logic     rst_n,
  ex_mult_if.mult  mul
);

  ex_pkg::mult_state_e                      state_q;
  ex_pkg::mult_state_e                      state_d;
  logic [$clog2(ex_pkg::MULT_CYCLES)-1:0]   cnt_q;
  logic                                     last_step;
  logic                                     busy;
  logic                                     start;
  logic                                     ext_sign;
  // Payload
  ex_pkg::mult_op_e                         op_q;
  logic signed [ex_pkg::DATA_W:0]           a_q;
  logic [ex_pkg::DATA_W:0]                  b_q;
  logic [2*ex_pkg::DATA_W-1:0]              acc_q;
  // One partial product
  logic [7:0]                               slice;
  logic                                     slice_ext;
  logic signed [ex_pkg::DATA_W+9:0]         part;
  logic signed [2*ex_pkg::DATA_W-1:0]       part_ext;

  assign start     = (state_q == ex_pkg::MS_IDLE) && mul.en;
  assign last_step = (cnt_q == ex_pkg::MULT_CYCLES - 1);
  // Only MUL_HSS treats operands as signed
  assign ext_sign  = (mul.operator == ex_pkg::MUL_HSS);

  ////////////////////
  // FSM
  ////////////////////

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      ex_pkg::MS_IDLE: if (mul.en) state_d = ex_pkg::MS_CALC;
      ex_pkg::MS_CALC: if (last_step) state_d = ex_pkg::MS_DONE;
      // Hold result until the stage moves on
      ex_pkg::MS_DONE: if (mul.ex_ready) state_d = ex_pkg::MS_IDLE;
      default:         state_d = ex_pkg::MS_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= ex_pkg::MS_IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      // Wraps back to zero after the last step
      if (state_q == ex_pkg::MS_CALC)
        cnt_q <= cnt_q + 1'b1;
      else
        cnt_q <= '0;
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  // Top byte carries the sign of b for signed high product
  assign slice     = b_q[{cnt_q, 3'b000} +: 8];
  assign slice_ext = last_step & b_q[ex_pkg::DATA_W];
  assign part      = a_q * $signed({slice_ext, slice});
  assign part_ext  = part;

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      op_q  <= mul.operator;
      a_q   <= {ext_sign & mul.op_a[ex_pkg::DATA_W-1], mul.op_a};
      b_q   <= {ext_sign & mul.op_b[ex_pkg::DATA_W-1], mul.op_b};
      // Seed with c for MAC
      acc_q <= (mul.operator == ex_pkg::MUL_MAC) ? {{ex_pkg::DATA_W{1'b0}}, mul.op_c} : '0;
    end
    else if (state_q == ex_pkg::MS_CALC)
    begin
      acc_q <= acc_q + (part_ext <<< {cnt_q, 3'b000});
    end
  end

  // Busy from the load cycle through the last accumulate step
  assign busy           = start || (state_q == ex_pkg::MS_CALC);
  assign mul.ready      = ~busy;
  assign mul.multicycle = busy;

  assign mul.result = ((op_q == ex_pkg::MUL_HSS) || (op_q == ex_pkg::MUL_HUU))
                    ? acc_q[2*ex_pkg::DATA_W-1:ex_pkg::DATA_W]
                    : acc_q[ex_pkg::DATA_W-1:0];

endmodule

//--- ex_alu.sv
// Single-cycle ALU
// Arithmetic, logic, shifts, set-less-than and branch comparison
`timescale 1ns/1ps

module ex_alu (
  ex_alu_if.alu alu
);

  logic                                sub_en;
  logic [ex_pkg::DATA_W-1:0]           b_inv;
  logic [ex_pkg::DATA_W:0]             sum;
  logic                                is_eq;
  logic                                lt_s;
  logic                                lt_u;
  logic [$clog2(ex_pkg::DATA_W)-1:0]   shamt;
  logic                                cmp;

  ////////////////////
  // Shared adder
  ////////////////////

  // Only ALU_ADD adds, every other user needs a - b
  assign sub_en = (alu.operator != ex_pkg::ALU_ADD);
  assign b_inv  = sub_en ? ~alu.operand_b : alu.operand_b;

  // Extra top bit catches the carry out
  assign sum = {1'b0, alu.operand_a} + {1'b0, b_inv}
             + {{ex_pkg::DATA_W{1'b0}}, sub_en};

  ////////////////////
  // Comparisons
  ////////////////////

  assign is_eq = (alu.operand_a == alu.operand_b);

  // Different signs: a is smaller iff a negative
  // Same signs: sign of the difference decides
  assign lt_s = (alu.operand_a[ex_pkg::DATA_W-1] != alu.operand_b[ex_pkg::DATA_W-1])
              ? alu.operand_a[ex_pkg::DATA_W-1]
              : sum[ex_pkg::DATA_W-1];

  // No carry out of a + ~b + 1 means a borrow
  assign lt_u = ~sum[ex_pkg::DATA_W];

  always_comb
  begin
    unique case (alu.operator)
      ex_pkg::ALU_EQ:  cmp = is_eq;
      ex_pkg::ALU_NE:  cmp = ~is_eq;
      ex_pkg::ALU_LT:  cmp = lt_s;
      ex_pkg::ALU_GE:  cmp = ~lt_s;
      ex_pkg::ALU_LTU: cmp = lt_u;
      ex_pkg::ALU_GEU: cmp = ~lt_u;
      // Non-branch operators report equality
      default:         cmp = is_eq;
    endcase
  end

  assign alu.cmp_result = cmp;

  ////////////////////
  // Result select
  ////////////////////

  // Shift amount from low bits of b
  assign shamt = alu.operand_b[$clog2(ex_pkg::DATA_W)-1:0];

  always_comb
  begin
    unique case (alu.operator)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB:  alu.result = sum[ex_pkg::DATA_W-1:0];
      ex_pkg::ALU_AND:  alu.result = alu.operand_a & alu.operand_b;
      ex_pkg::ALU_OR:   alu.result = alu.operand_a | alu.operand_b;
      ex_pkg::ALU_XOR:  alu.result = alu.operand_a ^ alu.operand_b;
      ex_pkg::ALU_SLL:  alu.result = alu.operand_a << shamt;
      ex_pkg::ALU_SRL:  alu.result = alu.operand_a >> shamt;
      // Arithmetic shift keeps the sign
      ex_pkg::ALU_SRA:  alu.result = $unsigned($signed(alu.operand_a) >>> shamt);
      ex_pkg::ALU_SLT:  alu.result = {{(ex_pkg::DATA_W-1){1'b0}}, lt_s};
      ex_pkg::ALU_SLTU: alu.result = {{(ex_pkg::DATA_W-1){1'b0}}, lt_u};
      // Branch operators return the decision, zero extended
      default:          alu.result = {{(ex_pkg::DATA_W-1){1'b0}}, cmp};
    endcase
  end

endmodule

//--- ex_intf.sv
// Execute stage internal interfaces
// ALU operand/result bundle and multiplier request/response bundle
`timescale 1ns/1ps

// Purely combinational, no handshake
interface ex_alu_if;
  ex_pkg::alu_op_e             operator;
  logic [ex_pkg::DATA_W-1:0]   operand_a;
  logic [ex_pkg::DATA_W-1:0]   operand_b;
  logic [ex_pkg::DATA_W-1:0]   result;
  logic                        cmp_result;

  modport stage (output operator, output operand_a, output operand_b,
                 input result, input cmp_result);
  modport alu (input operator, input operand_a, input operand_b,
               output result, output cmp_result);
endinterface

// Level request, ready/multicycle status back
interface ex_mult_if;
  logic                        en;
  ex_pkg::mult_op_e            operator;
  logic [ex_pkg::DATA_W-1:0]   op_a;
  logic [ex_pkg::DATA_W-1:0]   op_b;
  logic [ex_pkg::DATA_W-1:0]   op_c;
  // Stage can accept the next instruction
  logic                        ex_ready;
  logic [ex_pkg::DATA_W-1:0]   result;
  logic                        ready;
  logic                        multicycle;

  modport stage (output en, output operator, output op_a, output op_b, output op_c,
                 output ex_ready, input result, input ready, input multicycle);
  modport mult (input en, input operator, input op_a, input op_b, input op_c,
                input ex_ready, output result, output ready, output multicycle);
endinterface

//--- ex_pkg.sv
// Execute stage package
// Widths, multiplier latency and the operator and state encodings
package ex_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // One machine word
  localparam int DATA_W      = 32;
  // Register file index
  localparam int REG_ADDR_W  = 5;
  // Accumulate steps of the multiplier, one byte of op_b each
  localparam int MULT_CYCLES = 4;

  ////////////////////
  // ALU operators
  ////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    // Shifts
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    // Set less than
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    // Branch comparisons
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  ////////////////////
  // Multiplier
  ////////////////////

  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,  // low word of a*b
    MUL_HSS = 2'd1,  // high word, signed x signed
    MUL_HUU = 2'd2,  // high word, unsigned x unsigned
    MUL_MAC = 2'd3   // low word of a*b + c
  } mult_op_e;

  typedef enum logic [1:0] {
    MS_IDLE = 2'd0,
    MS_CALC = 2'd1,
    MS_DONE = 2'd2
  } mult_state_e;

endpackage
